// File: design/er_config.svh
`ifndef ER_CONFIG_SVH
`define ER_CONFIG_SVH

// stream and memory word widths
`define ER_FIFO_WIDTH           32
`define ER_KEY_WORD_WIDTH       64

// corrected key length in memory words
`define ER_KEY_WORDS            4
`define ER_KEY_ADDR_WIDTH       15

`define ER_HASHTAG_WIDTH        64
`define ER_ERROR_COUNT_WIDTH    12
`define ER_LEAKED_INFO_WIDTH    16

// estimate used before any frame has reported one
`define ER_DEFAULT_ERROR_COUNT  250

// hashtag packet header fields, top down, followed by 15 zero bits
`define ER_HDR_TYPE_TARGET_HASHTAG  4'd6
`define ER_HDR_LENGTH_CODE          4'd1
`define ER_HDR_TAG_DEPTH            9'd2

`endif

// File: design/er_pkg.sv
`include "er_config.svh"

package er_pkg;

    // stream fifo word
    typedef logic [`ER_FIFO_WIDTH-1:0] fifo_word_t;

    // reconciled key memory word and address
    typedef logic [`ER_KEY_WORD_WIDTH-1:0] key_word_t;
    typedef logic [`ER_KEY_ADDR_WIDTH-1:0] key_addr_t;

    // whole corrected key from cascade
    typedef logic [`ER_KEY_WORDS*`ER_KEY_WORD_WIDTH-1:0] corrected_key_t;

    typedef logic [`ER_HASHTAG_WIDTH-1:0] hashtag_t;

    // frame parameters reported by cascade
    typedef logic [`ER_ERROR_COUNT_WIDTH-1:0] error_count_t;
    typedef logic [`ER_LEAKED_INFO_WIDTH-1:0] leaked_info_t;

    // frame sequencer states
    typedef enum logic [3:0] {
        IDLE,
        CLEAR,
        CASCADE_START,
        CASCADE_BUSY,
        HASH_START,
        HASH_BUSY,
        READ_TAG,
        SEND_TAG,
        COMPARE,
        WRITE_KEY,
        DONE,
        FAIL
    } er_state_t;

endpackage

// File: design/tag_exchange_if.sv
interface tag_exchange_if;

    // sequencer requests
    logic clear;
    logic read_start;
    logic send_start;

    // exchange responses
    logic read_done;
    logic send_done;
    logic tags_match;

    modport sequencer (
        output clear, read_start, send_start,
        input  read_done, send_done, tags_match
    );

    modport exchange (
        input  clear, read_start, send_start,
        output read_done, send_done, tags_match
    );

endinterface

// File: design/er_sequencer.sv
`include "er_config.svh"

module er_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 cascade_param_valid,
    input  er_pkg::error_count_t cascade_error_count,
    input  er_pkg::leaked_info_t cascade_leaked_info,
    input  logic                 cascade_done,
    input  logic                 hash_valid,
    input  logic                 write_done,
    output logic                 cascade_start,
    output logic                 hash_start,
    output logic                 write_start,
    output er_pkg::error_count_t er_error_count,
    output er_pkg::leaked_info_t er_leaked_info,
    output logic                 er_parameter_valid,
    output logic                 verification_fail,
    output logic                 er_done,
    tag_exchange_if.sequencer    tag_if
);

    er_pkg::er_state_t state;
    er_pkg::er_state_t state_next;

    logic read_start_q;
    logic send_start_q;
    logic write_start_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= er_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            er_pkg::IDLE: begin
                if (start) begin
                    state_next = er_pkg::CLEAR;
                end
            end
            er_pkg::CLEAR:         state_next = er_pkg::CASCADE_START;
            er_pkg::CASCADE_START: state_next = er_pkg::CASCADE_BUSY;
            er_pkg::CASCADE_BUSY: begin
                if (cascade_done) begin
                    state_next = er_pkg::HASH_START;
                end
            end
            er_pkg::HASH_START:    state_next = er_pkg::HASH_BUSY;
            er_pkg::HASH_BUSY: begin
                if (hash_valid) begin
                    state_next = er_pkg::READ_TAG;
                end
            end
            er_pkg::READ_TAG: begin
                if (tag_if.read_done) begin
                    state_next = er_pkg::SEND_TAG;
                end
            end
            er_pkg::SEND_TAG: begin
                if (tag_if.send_done) begin
                    state_next = er_pkg::COMPARE;
                end
            end
            // single cycle decision on the tag comparison
            er_pkg::COMPARE: begin
                state_next = tag_if.tags_match ? er_pkg::WRITE_KEY : er_pkg::FAIL;
            end
            er_pkg::WRITE_KEY: begin
                if (write_done) begin
                    state_next = er_pkg::DONE;
                end
            end
            er_pkg::DONE:          state_next = er_pkg::IDLE;
            er_pkg::FAIL:          state_next = er_pkg::IDLE;
            default:               state_next = er_pkg::IDLE;
        endcase
    end

    // start pulses for the sub blocks, high in the first cycle of the next state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_start_q  <= 1'b0;
            send_start_q  <= 1'b0;
            write_start_q <= 1'b0;
        end else begin
            read_start_q  <= (state == er_pkg::HASH_BUSY) && hash_valid;
            send_start_q  <= (state == er_pkg::READ_TAG) && tag_if.read_done;
            write_start_q <= (state == er_pkg::COMPARE) && tag_if.tags_match;
        end
    end

    // frame parameters from cascade, the count carries over as next estimate
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            er_error_count <= er_pkg::error_count_t'(`ER_DEFAULT_ERROR_COUNT);
            er_leaked_info <= '0;
        end else if ((state == er_pkg::CASCADE_BUSY) && cascade_param_valid) begin
            er_error_count <= cascade_error_count;
            er_leaked_info <= cascade_leaked_info;
        end
    end

    assign cascade_start      = (state == er_pkg::CASCADE_START);
    assign hash_start         = (state == er_pkg::HASH_START);
    assign write_start        = write_start_q;

    assign tag_if.clear       = (state == er_pkg::CLEAR);
    assign tag_if.read_start  = read_start_q;
    assign tag_if.send_start  = send_start_q;

    // frame end, pass or fail
    assign er_done            = (state == er_pkg::DONE) || (state == er_pkg::FAIL);
    assign er_parameter_valid = er_done;
    assign verification_fail  = (state == er_pkg::FAIL);

endmodule

// File: design/hashtag_exchange.sv
`include "er_config.svh"

module hashtag_exchange (
    input  logic                 clk,
    input  logic                 rst_n,
    input  er_pkg::hashtag_t     hashtag,
    input  logic                 hash_valid,
    input  er_pkg::error_count_t est_error_count,
    input  er_pkg::fifo_word_t   b2a_dout,
    input  logic                 b2a_empty,
    input  logic                 b2a_rd_valid,
    input  logic                 a2b_full,
    output logic                 b2a_rd_en,
    output logic                 a2b_wr_en,
    output er_pkg::fifo_word_t   a2b_din,
    tag_exchange_if.exchange     tag_if
);

    // bob sends header then tag, alice sends header, tag, error count
    localparam logic [1:0] READ_WORDS = 2'd2;
    localparam logic [1:0] SEND_WORDS = 2'd3;

    localparam er_pkg::fifo_word_t HDR_WORD = {
        `ER_HDR_TYPE_TARGET_HASHTAG, `ER_HDR_LENGTH_CODE, `ER_HDR_TAG_DEPTH, 15'd0
    };

    er_pkg::hashtag_t   alice_tag;
    er_pkg::fifo_word_t bob_tag;

    logic       reading;
    logic       sending;
    logic [1:0] rd_req_cnt;
    logic [1:0] rd_got_cnt;
    logic [1:0] snd_cnt;
    logic       last_rd;

    // second returned word is bob's tag
    assign last_rd = reading && b2a_rd_valid && (rd_got_cnt == READ_WORDS - 2'd1);

    // request only while words are still owed and the fifo has data
    assign b2a_rd_en = reading && (rd_req_cnt < READ_WORDS) && !b2a_empty;
    assign a2b_wr_en = sending && (snd_cnt < SEND_WORDS) && !a2b_full;

    always_comb begin
        case (snd_cnt)
            2'd0:    a2b_din = HDR_WORD;
            2'd1:    a2b_din = alice_tag[`ER_HASHTAG_WIDTH-1 -: `ER_FIFO_WIDTH];
            2'd2:    a2b_din = {{(`ER_FIFO_WIDTH-`ER_ERROR_COUNT_WIDTH){1'b0}}, est_error_count};
            default: a2b_din = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reading          <= 1'b0;
            sending          <= 1'b0;
            rd_req_cnt       <= '0;
            rd_got_cnt       <= '0;
            snd_cnt          <= '0;
            tag_if.read_done <= 1'b0;
            tag_if.send_done <= 1'b0;
        end else begin
            tag_if.read_done <= 1'b0;
            tag_if.send_done <= 1'b0;
            if (tag_if.clear) begin
                reading    <= 1'b0;
                sending    <= 1'b0;
                rd_req_cnt <= '0;
                rd_got_cnt <= '0;
                snd_cnt    <= '0;
            end else begin
                if (tag_if.read_start) begin
                    reading <= 1'b1;
                end
                if (b2a_rd_en) begin
                    rd_req_cnt <= rd_req_cnt + 2'd1;
                end
                if (reading && b2a_rd_valid) begin
                    rd_got_cnt <= rd_got_cnt + 2'd1;
                end
                if (last_rd) begin
                    reading          <= 1'b0;
                    tag_if.read_done <= 1'b1;
                end
                if (tag_if.send_start) begin
                    sending <= 1'b1;
                end
                // one word leaves per accepted write
                if (a2b_wr_en) begin
                    snd_cnt <= snd_cnt + 2'd1;
                    if (snd_cnt == SEND_WORDS - 2'd1) begin
                        sending          <= 1'b0;
                        tag_if.send_done <= 1'b1;
                    end
                end
            end
        end
    end

    // tag registers, wiped at the start of every frame
    always_ff @(posedge clk) begin
        if (tag_if.clear) begin
            alice_tag <= '0;
            bob_tag   <= '0;
        end else begin
            if (hash_valid) begin
                alice_tag <= hashtag;
            end
            if (last_rd) begin
                bob_tag <= b2a_dout;
            end
        end
    end

    // bob only sends the upper half of his tag
    assign tag_if.tags_match = (alice_tag[`ER_HASHTAG_WIDTH-1 -: `ER_FIFO_WIDTH] == bob_tag);

endmodule

// File: design/reconciled_key_writer.sv
`include "er_config.svh"

module reconciled_key_writer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   write_start,
    input  er_pkg::corrected_key_t corrected_key,
    output logic                   write_done,
    output logic                   key_wr_en,
    output er_pkg::key_addr_t      key_addr,
    output er_pkg::key_word_t      key_data
);

    localparam int CNT_W = $clog2(`ER_KEY_WORDS + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`ER_KEY_WORDS);

    // words issued so far in this frame
    logic [CNT_W-1:0] word_cnt;
    logic [CNT_W-1:0] word_sel;
    er_pkg::key_addr_t addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_wr_en  <= 1'b0;
            write_done <= 1'b0;
            word_cnt   <= '0;
        end else begin
            write_done <= 1'b0;
            if (write_start) begin
                key_wr_en <= 1'b1;
                word_cnt  <= CNT_W'(1);
            end else if (key_wr_en) begin
                if (word_cnt == LAST_CNT) begin
                    key_wr_en  <= 1'b0;
                    write_done <= 1'b1;
                    word_cnt   <= '0;
                end else begin
                    word_cnt <= word_cnt + CNT_W'(1);
                end
            end
        end
    end

    // msw first
    assign word_sel = write_start ? '0 : word_cnt;

    always_ff @(posedge clk) begin
        if (write_start || (key_wr_en && (word_cnt != LAST_CNT))) begin
            key_data <= corrected_key[(`ER_KEY_WORDS - 1 - int'(word_sel)) * `ER_KEY_WORD_WIDTH
                                      +: `ER_KEY_WORD_WIDTH];
        end
    end

    // address keeps running across frames and wraps at the top
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (key_wr_en) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign key_addr = addr_q;

endmodule

// File: design/single_frame_er.sv
module single_frame_er (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    // cascade engine
    output logic                   cascade_start,
    input  logic                   cascade_param_valid,
    input  er_pkg::error_count_t   cascade_error_count,
    input  er_pkg::leaked_info_t   cascade_leaked_info,
    input  logic                   cascade_done,
    input  er_pkg::corrected_key_t corrected_key,
    // hash engine
    output logic                   hash_start,
    input  logic                   hash_valid,
    input  er_pkg::hashtag_t       hashtag,
    // b2a fifo read side
    output logic                   b2a_rd_en,
    input  er_pkg::fifo_word_t     b2a_dout,
    input  logic                   b2a_empty,
    input  logic                   b2a_rd_valid,
    // a2b fifo write side
    output logic                   a2b_wr_en,
    output er_pkg::fifo_word_t     a2b_din,
    input  logic                   a2b_full,
    // reconciled key memory
    output logic                   key_wr_en,
    output er_pkg::key_addr_t      key_addr,
    output er_pkg::key_word_t      key_data,
    // frame result
    output er_pkg::error_count_t   er_error_count,
    output er_pkg::leaked_info_t   er_leaked_info,
    output logic                   er_parameter_valid,
    output logic                   verification_fail,
    output logic                   er_done
);

    logic write_start;
    logic write_done;

    tag_exchange_if tag_if ();

    er_sequencer u_sequencer (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start               (start),
        .cascade_param_valid (cascade_param_valid),
        .cascade_error_count (cascade_error_count),
        .cascade_leaked_info (cascade_leaked_info),
        .cascade_done        (cascade_done),
        .hash_valid          (hash_valid),
        .write_done          (write_done),
        .cascade_start       (cascade_start),
        .hash_start          (hash_start),
        .write_start         (write_start),
        .er_error_count      (er_error_count),
        .er_leaked_info      (er_leaked_info),
        .er_parameter_valid  (er_parameter_valid),
        .verification_fail   (verification_fail),
        .er_done             (er_done),
        .tag_if              (tag_if.sequencer)
    );

    // sent error count is the estimate currently held by the sequencer
    hashtag_exchange u_exchange (
        .clk             (clk),
        .rst_n           (rst_n),
        .hashtag         (hashtag),
        .hash_valid      (hash_valid),
        .est_error_count (er_error_count),
        .b2a_dout        (b2a_dout),
        .b2a_empty       (b2a_empty),
        .b2a_rd_valid    (b2a_rd_valid),
        .a2b_full        (a2b_full),
        .b2a_rd_en       (b2a_rd_en),
        .a2b_wr_en       (a2b_wr_en),
        .a2b_din         (a2b_din),
        .tag_if          (tag_if.exchange)
    );

    reconciled_key_writer u_key_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .write_start   (write_start),
        .corrected_key (corrected_key),
        .write_done    (write_done),
        .key_wr_en     (key_wr_en),
        .key_addr      (key_addr),
        .key_data      (key_data)
    );

endmodule

// File: testbench/tb_single_frame_er.sv
`include "er_config.svh"

module tb_single_frame_er;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_FRAMES  = 20;

    logic                   clk                 = 1'b0;
    logic                   rst_n               = 1'b0;
    logic                   start               = 1'b0;
    logic                   cascade_param_valid = 1'b0;
    er_pkg::error_count_t   cascade_error_count = '0;
    er_pkg::leaked_info_t   cascade_leaked_info = '0;
    logic                   cascade_done        = 1'b0;
    er_pkg::corrected_key_t corrected_key       = '0;
    logic                   hash_valid          = 1'b0;
    er_pkg::hashtag_t       hashtag             = '0;
    er_pkg::fifo_word_t     b2a_dout            = '0;
    logic                   b2a_empty           = 1'b1;
    logic                   b2a_rd_valid        = 1'b0;
    logic                   a2b_full            = 1'b0;

    logic                   cascade_start;
    logic                   hash_start;
    logic                   b2a_rd_en;
    logic                   a2b_wr_en;
    er_pkg::fifo_word_t     a2b_din;
    logic                   key_wr_en;
    er_pkg::key_addr_t      key_addr;
    er_pkg::key_word_t      key_data;
    er_pkg::error_count_t   er_error_count;
    er_pkg::leaked_info_t   er_leaked_info;
    logic                   er_parameter_valid;
    logic                   verification_fail;
    logic                   er_done;

    // bob's fifo contents and logs of the dut's writes
    er_pkg::fifo_word_t bob_q[$];
    er_pkg::fifo_word_t a2b_log[$];
    er_pkg::key_addr_t  key_addr_log[$];
    int                 reads_seen = 0;
    er_pkg::key_word_t  key_mem [0:(1 << `ER_KEY_ADDR_WIDTH) - 1];

    // expected address of the next key write
    er_pkg::key_addr_t  next_addr = '0;

    always #4 clk = ~clk;

    single_frame_er dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start               (start),
        .cascade_start       (cascade_start),
        .cascade_param_valid (cascade_param_valid),
        .cascade_error_count (cascade_error_count),
        .cascade_leaked_info (cascade_leaked_info),
        .cascade_done        (cascade_done),
        .corrected_key       (corrected_key),
        .hash_start          (hash_start),
        .hash_valid          (hash_valid),
        .hashtag             (hashtag),
        .b2a_rd_en           (b2a_rd_en),
        .b2a_dout            (b2a_dout),
        .b2a_empty           (b2a_empty),
        .b2a_rd_valid        (b2a_rd_valid),
        .a2b_wr_en           (a2b_wr_en),
        .a2b_din             (a2b_din),
        .a2b_full            (a2b_full),
        .key_wr_en           (key_wr_en),
        .key_addr            (key_addr),
        .key_data            (key_data),
        .er_error_count      (er_error_count),
        .er_leaked_info      (er_leaked_info),
        .er_parameter_valid  (er_parameter_valid),
        .verification_fail   (verification_fail),
        .er_done             (er_done)
    );

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    // bob's fifo returns data one cycle after the read and goes empty at random
    always @(posedge clk) begin
        if (!rst_n) begin
            b2a_empty    <= 1'b1;
            b2a_rd_valid <= 1'b0;
        end else begin
            b2a_rd_valid <= 1'b0;
            if (b2a_rd_en === 1'b1) begin
                check_value("b2a read while empty", 1'b0, b2a_empty);
                b2a_dout     <= bob_q.pop_front();
                b2a_rd_valid <= 1'b1;
                reads_seen++;
            end
            b2a_empty <= (bob_q.size() == 0) || ($urandom_range(0, 3) == 0);
        end
    end

    // a2b sink with random full cycles
    always @(posedge clk) begin
        if (a2b_wr_en === 1'b1) begin
            check_value("a2b write while full", 1'b0, a2b_full);
            a2b_log.push_back(a2b_din);
        end
        a2b_full <= rst_n && ($urandom_range(0, 2) == 0);
    end

    // reconciled key memory
    always @(posedge clk) begin
        if (key_wr_en === 1'b1) begin
            key_mem[key_addr] = key_data;
            key_addr_log.push_back(key_addr);
        end
    end

    task automatic run_frame(input int idx, input bit tag_ok);
        er_pkg::error_count_t   err;
        er_pkg::leaked_info_t   leak;
        er_pkg::corrected_key_t key;
        er_pkg::hashtag_t       tag;
        er_pkg::fifo_word_t     bob_tag;
        er_pkg::fifo_word_t     hdr;
        er_pkg::key_addr_t      addr;
        er_pkg::key_word_t      word;
        int                     a2b_base;
        int                     key_base;
        int                     reads_base;
        int                     cycles;
        int                     lat_param;
        int                     lat_done;
        int                     lat_hash;
        string                  tn;

        tn   = $sformatf("frame %0d", idx);
        err  = er_pkg::error_count_t'($urandom());
        leak = er_pkg::leaked_info_t'($urandom());
        for (int i = 0; i < `ER_KEY_WORDS * 2; i++) begin
            key[i*32 +: 32] = $urandom();
        end
        tag = {$urandom(), $urandom()};
        // a wrong tag differs from alice's upper half in at least one bit
        bob_tag   = tag_ok ? tag[63:32] : (tag[63:32] ^ ($urandom() | 32'd1));
        hdr       = {`ER_HDR_TYPE_TARGET_HASHTAG, `ER_HDR_LENGTH_CODE, `ER_HDR_TAG_DEPTH, 15'd0};
        lat_param = $urandom_range(0, 6);
        lat_done  = $urandom_range(0, 4);
        lat_hash  = $urandom_range(0, 8);

        @(negedge clk);
        a2b_base   = a2b_log.size();
        key_base   = key_addr_log.size();
        reads_base = reads_seen;

        // bob's header word is ignored by alice
        bob_q.push_back($urandom());
        bob_q.push_back(bob_tag);

        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 1;
        while (cascade_start !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("%s: cascade_start never came after start", tn);
                abort_run();
            end
        end
        // one edge samples start and two more cover CLEAR and CASCADE_START
        check_value({tn, " cascade_start delay"}, 3, cycles);

        // cascade engine reports params at or before done
        repeat (lat_param) @(posedge clk);
        cascade_param_valid <= 1'b1;
        cascade_error_count <= err;
        cascade_leaked_info <= leak;
        corrected_key       <= key;
        cascade_done        <= (lat_done == 0);
        @(posedge clk);
        cascade_param_valid <= 1'b0;
        cascade_done        <= 1'b0;
        if (lat_done != 0) begin
            repeat (lat_done - 1) @(posedge clk);
            cascade_done <= 1'b1;
            @(posedge clk);
            cascade_done <= 1'b0;
        end

        cycles = 0;
        while (hash_start !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("%s: hash_start never came after cascade_done", tn);
                abort_run();
            end
        end
        check_value({tn, " hash_start delay"}, 1, cycles);

        // hash engine
        repeat (lat_hash) @(posedge clk);
        hashtag    <= tag;
        hash_valid <= 1'b1;
        @(posedge clk);
        hash_valid <= 1'b0;

        cycles = 0;
        while (er_done !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("%s: er_done never came after hash_valid", tn);
                abort_run();
            end
        end

        check_value({tn, " verification_fail"}, !tag_ok, verification_fail);
        check_value({tn, " er_parameter_valid"}, 1'b1, er_parameter_valid);
        check_value({tn, " er_error_count"}, err, er_error_count);
        check_value({tn, " er_leaked_info"}, leak, er_leaked_info);

        // packet sent to bob
        check_value({tn, " b2a reads"}, 2, reads_seen - reads_base);
        check_value({tn, " a2b words"}, 3, a2b_log.size() - a2b_base);
        check_value({tn, " a2b header"}, hdr, a2b_log[a2b_base]);
        check_value({tn, " a2b tag"}, tag[63:32], a2b_log[a2b_base + 1]);
        check_value({tn, " a2b error count"}, er_pkg::fifo_word_t'(err), a2b_log[a2b_base + 2]);

        if (tag_ok) begin
            check_value({tn, " key writes"}, `ER_KEY_WORDS, key_addr_log.size() - key_base);
            for (int i = 0; i < `ER_KEY_WORDS; i++) begin
                addr = next_addr + er_pkg::key_addr_t'(i);
                word = key[(`ER_KEY_WORDS - 1 - i) * `ER_KEY_WORD_WIDTH +: `ER_KEY_WORD_WIDTH];
                check_value({tn, " key address"}, addr, key_addr_log[key_base + i]);
                check_value({tn, " key memory"}, word, key_mem[addr]);
            end
            next_addr = next_addr + er_pkg::key_addr_t'(`ER_KEY_WORDS);
        end else begin
            check_value({tn, " key writes"}, 0, key_addr_log.size() - key_base);
        end

        @(posedge clk);
        check_value({tn, " er_done pulse width"}, 1'b0, er_done);
    endtask

    initial begin
        void'($urandom(32'h1ca2_ac86));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        check_value("reset er_error_count", `ER_DEFAULT_ERROR_COUNT, er_error_count);
        check_value("reset er_leaked_info", 0, er_leaked_info);
        check_value("reset strobes", 0, {cascade_start, hash_start, b2a_rd_en, a2b_wr_en,
                                         key_wr_en, er_done, er_parameter_valid,
                                         verification_fail});

        run_frame(0, 1'b1);
        run_frame(1, 1'b0);
        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            run_frame(f + 2, $urandom_range(0, 3) != 0);
        end

        repeat (5) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+design
design/er_pkg.sv
design/tag_exchange_if.sv
design/er_sequencer.sv
design/hashtag_exchange.sv
design/reconciled_key_writer.sv
design/single_frame_er.sv
testbench/tb_single_frame_er.sv

// File: Makefile
# Verilator build and run of the single frame error reconciliation testbench

TOP := tb_single_frame_er

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		-f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only -Wall -Idesign \
		design/er_pkg.sv design/tag_exchange_if.sv design/er_sequencer.sv \
		design/hashtag_exchange.sv design/reconciled_key_writer.sv \
		design/single_frame_er.sv --top-module single_frame_er

clean:
	rm -rf obj_dir sim.log
